// ==== common/clock_pkg.sv ====
package clock_pkg;

	// ---------------------------------------------------------------------
	// time of day and alarm time
	// ---------------------------------------------------------------------
	typedef struct packed {
		logic [5:0] hr;		// 0..23
		logic [5:0] min;	// 0..59
		logic [5:0] sec;	// 0..59
	} hms_t;

	localparam logic [5:0] SEC_MAX = 6'd59;
	localparam logic [5:0] MIN_MAX = 6'd59;
	localparam logic [5:0] HR_MAX  = 6'd23;

	// ---------------------------------------------------------------------
	// user controls
	// ---------------------------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		FIELD_SEC = 2'd0,
		FIELD_MIN = 2'd1,
		FIELD_HR  = 2'd2
	} field_e;

	// single-cycle button strobes
	typedef struct packed {
		logic mode;		// next mode
		logic field;	// next field
		logic inc;		// bump selected field
		logic alarm;	// toggle alarm enable
	} btn_t;

	// add one to a field, no carry into the next
	typedef struct packed {
		logic sec;
		logic min;
		logic hr;
	} field_inc_t;

	// tick divisors for a 50 MHz clk
	localparam logic [31:0] DIV_SEC_DEFAULT   = 32'd50_000_000;	// 1 Hz
	localparam logic [31:0] DIV_SCAN_DEFAULT  = 32'd5_000;		// 10 kHz digit scan
	localparam logic [31:0] DIV_BLINK_DEFAULT = 32'd12_500_000;	// 4 Hz phase toggle

endpackage

// ==== common/display_pkg.sv ====
package display_pkg;

	localparam int NUM_DIGITS = 6;

	typedef logic [6:0] seg_t;						// {a,b,c,d,e,f,g}, 1 = lit
	typedef logic [NUM_DIGITS-1:0] digit_en_t;		// 0 = digit driven
	typedef seg_t [NUM_DIGITS-1:0] digits_t;		// [0] is seconds ones

	// ---------------------------------------------------------------------
	// glyphs
	// ---------------------------------------------------------------------
	localparam seg_t GLYPH_0 = 7'b111_1110;
	localparam seg_t GLYPH_1 = 7'b011_0000;
	localparam seg_t GLYPH_2 = 7'b110_1101;
	localparam seg_t GLYPH_3 = 7'b111_1001;
	localparam seg_t GLYPH_4 = 7'b011_0011;
	localparam seg_t GLYPH_5 = 7'b101_1011;
	localparam seg_t GLYPH_6 = 7'b101_1111;
	localparam seg_t GLYPH_7 = 7'b111_0000;
	localparam seg_t GLYPH_8 = 7'b111_1111;
	localparam seg_t GLYPH_9 = 7'b111_0011;

	localparam seg_t GLYPH_BLANK = 7'b000_0000;	// all segments dark

endpackage

// ==== verilog/tick_gen.sv ====
`timescale 1ns/10ps

module tick_gen #(
	parameter logic [31:0] p_div_sec   = clock_pkg::DIV_SEC_DEFAULT,
	parameter logic [31:0] p_div_scan  = clock_pkg::DIV_SCAN_DEFAULT,
	parameter logic [31:0] p_div_blink = clock_pkg::DIV_BLINK_DEFAULT
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick,
	output logic o_blink_tick
);

	localparam int c_num_ticks = 3;
	localparam logic [31:0] c_div [c_num_ticks] = '{p_div_sec, p_div_scan, p_div_blink};

	logic [31:0] cnt [c_num_ticks];
	logic [c_num_ticks-1:0] hit;

	// strobe on the last count of each period
	always_comb begin
		for (int i = 0; i < c_num_ticks; i++) begin
			hit[i] = (cnt[i] == c_div[i] - 32'd1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < c_num_ticks; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < c_num_ticks; i++) begin
				cnt[i] <= hit[i] ? 32'd0 : cnt[i] + 32'd1;	// free running
			end
		end
	end

	assign o_sec_tick   = hit[0];
	assign o_scan_tick  = hit[1];
	assign o_blink_tick = hit[2];

endmodule

// ==== timekeep/hms_counter.sv ====
`timescale 1ns/10ps

module hms_counter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_run,
	input  clock_pkg::field_inc_t i_inc,
	output clock_pkg::hms_t       o_time
);

	import clock_pkg::*;

	hms_t time_q;
	hms_t time_nxt;

	// one step with wrap at the field limit
	function automatic logic [5:0] wrap_inc(input logic [5:0] val, input logic [5:0] lim);
		return (val >= lim) ? 6'd0 : val + 6'd1;
	endfunction

	// ---------------------------------------------------------------------
	// next value
	// ---------------------------------------------------------------------
	always_comb begin
		time_nxt = time_q;
		if (i_run) begin
			time_nxt.sec = wrap_inc(time_q.sec, SEC_MAX);
			if (time_q.sec == SEC_MAX) begin
				time_nxt.min = wrap_inc(time_q.min, MIN_MAX);	// carry into minutes
				if (time_q.min == MIN_MAX)
					time_nxt.hr = wrap_inc(time_q.hr, HR_MAX);
			end
		end
		// manual bumps, no carry
		if (i_inc.sec) time_nxt.sec = wrap_inc(time_q.sec, SEC_MAX);
		if (i_inc.min) time_nxt.min = wrap_inc(time_q.min, MIN_MAX);
		if (i_inc.hr)  time_nxt.hr  = wrap_inc(time_q.hr, HR_MAX);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_q <= '0;	// 00:00:00
		end else begin
			time_q <= time_nxt;
		end
	end

	assign o_time = time_q;

endmodule

// ==== timekeep/clock_ctrl.sv ====
`timescale 1ns/10ps

module clock_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  clock_pkg::btn_t        i_btn,
	input  logic                   i_sec_tick,
	input  logic                   i_blink_tick,
	input  clock_pkg::hms_t        i_cur_time,
	input  clock_pkg::hms_t        i_alarm_time,
	output logic                   o_run,
	output clock_pkg::field_inc_t  o_time_inc,
	output clock_pkg::field_inc_t  o_alarm_inc,
	output clock_pkg::hms_t        o_shown,
	output display_pkg::digit_en_t o_blank,
	output logic                   o_alarm
);

	import clock_pkg::*;

	mode_e      mode_q;
	field_e     field_q;
	logic       alarm_en_q;
	logic       alarm_q;
	logic       blink_on_q;	// 1 = selected field shown
	field_inc_t sel_inc;

	// ---------------------------------------------------------------------
	// mode, field, alarm enable and blink phase
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q     <= MODE_CLOCK;
			field_q    <= FIELD_SEC;
			alarm_en_q <= 1'b0;
			blink_on_q <= 1'b1;
		end else begin
			if (i_btn.mode) begin
				case (mode_q)
					MODE_CLOCK: mode_q <= MODE_SETUP;
					MODE_SETUP: mode_q <= MODE_ALARM;
					default:    mode_q <= MODE_CLOCK;
				endcase
			end
			if (i_btn.field) begin
				case (field_q)
					FIELD_SEC: field_q <= FIELD_MIN;
					FIELD_MIN: field_q <= FIELD_HR;
					default:   field_q <= FIELD_SEC;
				endcase
			end
			if (i_btn.alarm) alarm_en_q <= ~alarm_en_q;
			if (i_blink_tick) blink_on_q <= ~blink_on_q;
		end
	end

	// latched until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_q <= 1'b0;
		end else if (!alarm_en_q) begin
			alarm_q <= 1'b0;
		end else if (i_cur_time == i_alarm_time) begin
			alarm_q <= 1'b1;
		end
	end

	// ---------------------------------------------------------------------
	// increment routing
	// ---------------------------------------------------------------------
	always_comb begin
		sel_inc = '0;
		if (i_btn.inc) begin
			case (field_q)
				FIELD_SEC: sel_inc.sec = 1'b1;
				FIELD_MIN: sel_inc.min = 1'b1;
				default:   sel_inc.hr  = 1'b1;
			endcase
		end
	end

	assign o_run       = i_sec_tick && (mode_q != MODE_SETUP);	// frozen while setting
	assign o_time_inc  = (mode_q == MODE_SETUP) ? sel_inc : '0;
	assign o_alarm_inc = (mode_q == MODE_ALARM) ? sel_inc : '0;
	assign o_shown     = (mode_q == MODE_ALARM) ? i_alarm_time : i_cur_time;
	assign o_alarm     = alarm_q;

	// blank the selected pair during the off phase
	always_comb begin
		o_blank = '0;
		if (mode_q != MODE_CLOCK && !blink_on_q) begin
			case (field_q)
				FIELD_SEC: o_blank = 6'b000011;
				FIELD_MIN: o_blank = 6'b001100;
				default:   o_blank = 6'b110000;
			endcase
		end
	end

endmodule

// ==== display/digit_encoder.sv ====
`timescale 1ns/10ps

module digit_encoder (
	input  clock_pkg::hms_t        i_shown,
	input  display_pkg::digit_en_t i_blank,
	output display_pkg::digits_t   o_digits
);

	import display_pkg::*;

	logic [5:0] fld [3];	// sec, min, hr
	logic [3:0] tens;
	logic [3:0] ones;

	function automatic seg_t glyph(input logic [3:0] num);
		case (num)
			4'd0:    return GLYPH_0;
			4'd1:    return GLYPH_1;
			4'd2:    return GLYPH_2;
			4'd3:    return GLYPH_3;
			4'd4:    return GLYPH_4;
			4'd5:    return GLYPH_5;
			4'd6:    return GLYPH_6;
			4'd7:    return GLYPH_7;
			4'd8:    return GLYPH_8;
			4'd9:    return GLYPH_9;
			default: return GLYPH_BLANK;	// out of range
		endcase
	endfunction

	assign fld[0] = i_shown.sec;
	assign fld[1] = i_shown.min;
	assign fld[2] = i_shown.hr;

	// even index is ones, odd index is tens
	always_comb begin
		tens = '0;
		ones = '0;
		for (int i = 0; i < 3; i++) begin
			tens = 4'(fld[i] / 6'd10);
			ones = 4'(fld[i] % 6'd10);
			o_digits[2*i]   = i_blank[2*i]   ? GLYPH_BLANK : glyph(ones);
			o_digits[2*i+1] = i_blank[2*i+1] ? GLYPH_BLANK : glyph(tens);
		end
	end

endmodule

// ==== display/scan_mux.sv ====
`timescale 1ns/10ps

module scan_mux (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_scan_tick,
	input  display_pkg::digits_t   i_digits,
	output display_pkg::seg_t      o_seg,
	output display_pkg::digit_en_t o_seg_enb
);

	import display_pkg::*;

	localparam int c_idx_w = $clog2(NUM_DIGITS);
	localparam logic [c_idx_w-1:0] c_idx_last = c_idx_w'(NUM_DIGITS - 1);

	logic [c_idx_w-1:0] idx_q;	// digit being driven

	// ---------------------------------------------------------------------
	// scan index, 0..5
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx_q <= '0;
		end else if (i_scan_tick) begin
			idx_q <= (idx_q == c_idx_last) ? '0 : idx_q + 1'b1;
		end
	end

	assign o_seg     = i_digits[idx_q];
	assign o_seg_enb = ~(digit_en_t'(1) << idx_q);	// one low at a time

endmodule

// ==== verilog/digital_clock_top.sv ====
`timescale 1ns/10ps

module digital_clock_top #(
	parameter logic [31:0] p_div_sec   = clock_pkg::DIV_SEC_DEFAULT,
	parameter logic [31:0] p_div_scan  = clock_pkg::DIV_SCAN_DEFAULT,
	parameter logic [31:0] p_div_blink = clock_pkg::DIV_BLINK_DEFAULT
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  clock_pkg::btn_t        i_btn,
	output display_pkg::seg_t      o_seg,
	output display_pkg::digit_en_t o_seg_enb,
	output logic                   o_alarm
);

	import clock_pkg::*;
	import display_pkg::*;

	logic       sec_tick;
	logic       scan_tick;
	logic       blink_tick;
	logic       run_tick;
	field_inc_t time_inc;
	field_inc_t alarm_inc;
	hms_t       cur_time;
	hms_t       alarm_time;
	hms_t       shown;
	digit_en_t  blank;
	digits_t    digits;

	tick_gen #(
		.p_div_sec   (p_div_sec),
		.p_div_scan  (p_div_scan),
		.p_div_blink (p_div_blink)
	) u_tick_gen (
		.clk          (clk),
		.rst_n        (rst_n),
		.o_sec_tick   (sec_tick),
		.o_scan_tick  (scan_tick),
		.o_blink_tick (blink_tick)
	);

	// ---------------------------------------------------------------------
	// running time and alarm setting
	// ---------------------------------------------------------------------
	hms_counter u_time (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_run  (run_tick),
		.i_inc  (time_inc),
		.o_time (cur_time)
	);

	hms_counter u_alarm (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_run  (1'b0),		// alarm time only moves by hand
		.i_inc  (alarm_inc),
		.o_time (alarm_time)
	);

	clock_ctrl u_clock_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_btn        (i_btn),
		.i_sec_tick   (sec_tick),
		.i_blink_tick (blink_tick),
		.i_cur_time   (cur_time),
		.i_alarm_time (alarm_time),
		.o_run        (run_tick),
		.o_time_inc   (time_inc),
		.o_alarm_inc  (alarm_inc),
		.o_shown      (shown),
		.o_blank      (blank),
		.o_alarm      (o_alarm)
	);

	// ---------------------------------------------------------------------
	// display path
	// ---------------------------------------------------------------------
	digit_encoder u_digit_encoder (
		.i_shown  (shown),
		.i_blank  (blank),
		.o_digits (digits)
	);

	scan_mux u_scan_mux (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_digits    (digits),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

// ==== dv/tb_digital_clock.sv ====
`timescale 1ns/10ps

module tb_digital_clock;

	import clock_pkg::*;
	import display_pkg::*;

	localparam int c_div_sec  = 64;
	localparam int c_max_wait = 16;
	localparam int c_num_rows = 21;
	// button codes used in the table
	localparam logic [2:0] c_none  = 3'd0;
	localparam logic [2:0] c_mode  = 3'd1;
	localparam logic [2:0] c_field = 3'd2;
	localparam logic [2:0] c_inc   = 3'd3;
	localparam logic [2:0] c_alarm = 3'd4;

	// one step: button, press count, seconds to wait, expected o_alarm
	typedef struct packed {
		logic [2:0] btn;
		logic [6:0] count;
		logic [4:0] wait_s;
		logic       exp_alarm;
	} row_t;

	localparam row_t c_table [c_num_rows] = '{
		'{c_none,  7'd0,  5'd0,  1'b0},	// after reset
		'{c_mode,  7'd1,  5'd0,  1'b0},	// setup
		'{c_field, 7'd1,  5'd0,  1'b0},	// minutes
		'{c_inc,   7'd59, 5'd0,  1'b0},
		'{c_field, 7'd2,  5'd0,  1'b0},	// hours, then back to seconds
		'{c_inc,   7'd60, 5'd2,  1'b0},	// full wrap, time frozen
		'{c_inc,   7'd55, 5'd0,  1'b0},	// 00:59:55
		'{c_mode,  7'd2,  5'd8,  1'b0},	// run across the hour
		'{c_mode,  7'd2,  5'd0,  1'b0},	// alarm mode
		'{c_field, 7'd2,  5'd0,  1'b0},
		'{c_inc,   7'd1,  5'd0,  1'b0},	// alarm hour 01
		'{c_field, 7'd1,  5'd0,  1'b0},
		'{c_inc,   7'd20, 5'd1,  1'b0},	// alarm 01:00:20
		'{c_mode,  7'd1,  5'd0,  1'b0},	// back to clock
		'{c_alarm, 7'd1,  5'd0,  1'b0},	// enable
		'{c_none,  7'd0,  5'd16, 1'b1},	// match passed
		'{c_none,  7'd0,  5'd2,  1'b1},	// still latched
		'{c_alarm, 7'd1,  5'd0,  1'b0},	// disable clears
		'{c_mode,  7'd2,  5'd0,  1'b0},
		'{c_inc,   7'd15, 5'd0,  1'b0},	// alarm 01:00:35
		'{c_mode,  7'd1,  5'd12, 1'b0}		// disabled match
	};

	localparam seg_t c_glyphs [10] = '{
		7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001, 7'b0110011,
		7'b1011011, 7'b1011111, 7'b1110000, 7'b1111111, 7'b1110011
	};

	logic      clk;
	logic      rst_n;
	btn_t      i_btn;
	seg_t      o_seg;
	digit_en_t o_seg_enb;
	logic      o_alarm;

	int   errors;
	// reference model state
	hms_t cur_m;
	hms_t alm_m;
	int   mode_m;
	int   field_m;
	int   div_cnt;

	digital_clock_top #(
		.p_div_sec   (32'd64),
		.p_div_scan  (32'd2),
		.p_div_blink (32'd1_000_000)	// never blinks here
	) u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_btn     (i_btn),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb),
		.o_alarm   (o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [5:0] step_wrap(input logic [5:0] v, input int lim);
		return (int'(v) >= lim) ? 6'd0 : v + 6'd1;
	endfunction

	// one second with full carry
	function automatic hms_t second_step(input hms_t t);
		hms_t n;
		n = t;
		n.sec = step_wrap(t.sec, 59);
		if (t.sec == 6'd59) begin
			n.min = step_wrap(t.min, 59);
			if (t.min == 6'd59) n.hr = step_wrap(t.hr, 23);
		end
		return n;
	endfunction

	function automatic hms_t field_step(input hms_t t, input int f);
		hms_t n;
		n = t;
		if (f == 0) n.sec = step_wrap(t.sec, 59);
		else if (f == 1) n.min = step_wrap(t.min, 59);
		else n.hr = step_wrap(t.hr, 23);
		return n;
	endfunction

	function automatic int glyph_digit(input seg_t s);
		for (int i = 0; i < 10; i++) begin
			if (s == c_glyphs[i]) return i;
		end
		return -1;
	endfunction

	// ------------------------------------------------------------------
	// reference model, updated on the same edges as the DUT
	// ------------------------------------------------------------------
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_m   = '0;
			alm_m   = '0;
			mode_m  = 0;
			field_m = 0;
			div_cnt = 0;
		end else begin
			if (div_cnt == c_div_sec - 1) begin
				div_cnt = 0;
				if (mode_m != 1) cur_m = second_step(cur_m);	// frozen in setup
			end else begin
				div_cnt = div_cnt + 1;
			end
			if (i_btn.inc && mode_m == 1) cur_m = field_step(cur_m, field_m);
			if (i_btn.inc && mode_m == 2) alm_m = field_step(alm_m, field_m);
			if (i_btn.mode) mode_m = (mode_m + 1) % 3;
			if (i_btn.field) field_m = (field_m + 1) % 3;
		end
	end

	task automatic press_button(input int code, input int count);
		repeat (count) begin
			@(posedge clk);
			#1;
			i_btn.mode  = (code == c_mode);
			i_btn.field = (code == c_field);
			i_btn.inc   = (code == c_inc);
			i_btn.alarm = (code == c_alarm);
			@(posedge clk);
			#1;
			i_btn = '0;
		end
	endtask

	// catch each digit enable in turn and compare with the model
	task automatic read_display(input int row);
		hms_t shown;
		int   fld;
		int   expd;
		int   got;
		for (int k = 0; k < NUM_DIGITS; k++) begin
			do begin
				@(negedge clk);
				if ($countones(~o_seg_enb) != 1) begin
					errors++;
					$display("error at %0t: row %0d enables %b", $time, row, o_seg_enb);
				end
			end while (o_seg_enb[k] !== 1'b0);
			shown = (mode_m == 2) ? alm_m : cur_m;
			fld = (k < 2) ? int'(shown.sec) : (k < 4) ? int'(shown.min) : int'(shown.hr);
			expd = (k % 2 == 0) ? fld % 10 : fld / 10;
			got = glyph_digit(o_seg);
			if (got != expd) begin
				errors++;
				$display("error at %0t: row %0d digit %0d seg %b expected %0d",
					$time, row, k, o_seg, expd);
			end
		end
	endtask

	initial begin
		#(c_num_rows * (c_max_wait + 2) * c_div_sec * 8 + 20000);
		$display("timeout: the test sequence did not finish in time");
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		errors = 0;
		rst_n  = 1'b0;
		i_btn  = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int r = 0; r < c_num_rows; r++) begin
			press_button(int'(c_table[r].btn), int'(c_table[r].count));
			repeat (int'(c_table[r].wait_s) * c_div_sec) @(posedge clk);
			read_display(r);
			@(negedge clk);
			if (o_alarm !== c_table[r].exp_alarm) begin
				errors++;
				$display("error at %0t: row %0d o_alarm %b expected %b",
					$time, r, o_alarm, c_table[r].exp_alarm);
			end
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
common/clock_pkg.sv
common/display_pkg.sv
verilog/tick_gen.sv
timekeep/hms_counter.sv
timekeep/clock_ctrl.sv
display/digit_encoder.sv
display/scan_mux.sv
verilog/digital_clock_top.sv
dv/tb_digital_clock.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_digital_clock -f all.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "compile failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
	echo "test failed, see sim.log"
	exit 1
fi
echo "test passed"
exit 0
